/* verilog.f */
+incdir+logic
logic/mips_pkg.sv
logic/register_file.sv
logic/control_decoder.sv
logic/decode_stage.sv
verif/decode_stage_tb.sv

/* verif/decode_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module decode_stage_tb;

   import mips_pkg::*;

   localparam int CLK_PERIOD   = 10;
   localparam int RESET_CYCLES = 10;
   // reset, regfile, immediates, special, branches, jumps
   localparam int TEST_CYCLES  = RESET_CYCLES + 1 + 66 + 32 + 12 + 24 + 6;
   localparam int MARGIN       = 50;   // cycles

   logic                i_clk;
   logic                i_rst;
   logic [`NB_BITS-1:0] i_pc;
   logic [`NB_BITS-1:0] i_instr;
   logic [`NB_BITS-1:0] i_wb_data;
   logic [`NB_REG-1:0]  i_wb_dst;
   logic                i_wb_we;
   logic [`NB_BITS-1:0] o_id_ex_pc, o_id_ex_rs, o_id_ex_rt, o_id_ex_imm;
   logic [`NB_REG-1:0]  o_id_ex_rt_num, o_id_ex_rd_num;
   alu_op_e             o_id_ex_alu_op;
   src_a_e              o_id_ex_src_a;
   logic                o_id_ex_src_b_imm;
   dest_e               o_id_ex_dest;
   logic [`NB_JMP-1:0]  o_jmp_addr;
   logic [`NB_BITS-1:0] o_brh_addr;
   logic                o_pc_src, o_pc_beq, o_flush;

   logic [`NB_BITS-1:0] shadow [`N_REGS];   // expected register contents
   string               test_name;
   int                  errors;

   decode_stage u_decode_stage (.*);

   initial begin
      i_clk = 1'b0;
      forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
   end

   initial begin
      #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
      $display("timeout: the tests did not finish within %0d cycles", TEST_CYCLES + MARGIN);
      $display("Errors found");
      $finish;
   end

   task automatic report(input string what, input string exp, input string act);
      errors++;
      $display("mismatch in %s, %s: expected %s, actual %s", test_name, what, exp, act);
   endtask

   task automatic check_word(input string what, input logic [`NB_BITS-1:0] exp,
                             input logic [`NB_BITS-1:0] act);
      if (act !== exp) report(what, $sformatf("%h", exp), $sformatf("%h", act));
   endtask

   task automatic check_num(input string what, input logic [`NB_REG-1:0] exp,
                            input logic [`NB_REG-1:0] act);
      if (act !== exp) report(what, $sformatf("%0d", exp), $sformatf("%0d", act));
   endtask

   task automatic check_alu(input string what, input alu_op_e exp, input alu_op_e act);
      if (act !== exp) report(what, exp.name(), $sformatf("%s(%0d)", act.name(), act));
   endtask

   task automatic check_src(input string what, input src_a_e exp, input src_a_e act);
      if (act !== exp) report(what, exp.name(), $sformatf("%s(%0d)", act.name(), act));
   endtask

   task automatic check_dest(input string what, input dest_e exp, input dest_e act);
      if (act !== exp) report(what, exp.name(), $sformatf("%s(%0d)", act.name(), act));
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (act !== exp) report(what, $sformatf("%b", exp), $sformatf("%b", act));
   endtask

   // decode table for the execute controls
   task automatic ref_ctrl(input logic [5:0] op, output alu_op_e alu, output src_a_e src,
                           output logic imm_b, output dest_e dest);
      src   = SRC_A_PC;
      imm_b = 1'b0;
      dest  = DEST_RD;
      case (op)
         OP_ADDI, OP_LW, OP_SW: alu = ALU_ADD;
         OP_SLTI:    alu = ALU_SLT;
         OP_ANDI:    alu = ALU_AND;
         OP_ORI:     alu = ALU_OR;
         OP_XORI:    alu = ALU_XOR;
         OP_LUI:     alu = ALU_LUI;
         OP_JAL:     alu = ALU_JAL;
         OP_SPECIAL: alu = ALU_FUNC;
         default:    alu = ALU_NONE;
      endcase
      case (op)
         OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LW, OP_SW: begin
            src   = SRC_A_RS;
            imm_b = 1'b1;
            dest  = DEST_RT;
         end
         OP_LUI: begin
            imm_b = 1'b1;
            dest  = DEST_RT;
         end
         OP_JAL:     dest = DEST_R31;
         OP_SPECIAL: src  = SRC_A_SHAMT;
         default: ;
      endcase
   endtask

   task automatic write_reg(input logic [`NB_REG-1:0] addr, input logic [`NB_BITS-1:0] data);
      @(negedge i_clk);
      i_wb_we   = 1'b1;
      i_wb_dst  = addr;
      i_wb_data = data;
      if (addr != '0) shadow[addr] = data;   // r0 keeps 0
      @(posedge i_clk);
      #1;
   endtask

   // one instruction: redirects before the edge, id/ex entry after it
   task automatic run_instr(input logic [`NB_BITS-1:0] pc, input logic [`NB_BITS-1:0] instr);
      logic [5:0]          op;
      logic [`NB_BITS-1:0] rs_val;
      logic [`NB_BITS-1:0] rt_val;
      logic [`NB_BITS-1:0] sext;
      logic [`NB_BITS-1:0] imm;
      logic                jump;
      logic                taken;
      alu_op_e             alu;
      src_a_e              src;
      logic                imm_b;
      dest_e               dest;
      op     = instr[31:26];
      rs_val = shadow[instr[25:21]];
      rt_val = shadow[instr[20:16]];
      sext   = {{16{instr[15]}}, instr[15:0]};
      case (op)
         OP_J, OP_JAL: imm = {6'b0, instr[25:0]};
         OP_ANDI, OP_ORI, OP_XORI, OP_LUI: imm = {16'b0, instr[15:0]};
         OP_SPECIAL: imm = {27'b0, instr[10:6]};
         default:    imm = sext;
      endcase
      jump  = (op == OP_J) || (op == OP_JAL) ||
              (op == OP_SPECIAL && (instr[5:0] == FN_JR || instr[5:0] == FN_JALR));
      taken = (op == OP_BEQ && rs_val == rt_val) || (op == OP_BNE && rs_val != rt_val);
      ref_ctrl(op, alu, src, imm_b, dest);
      @(negedge i_clk);
      i_wb_we = 1'b0;
      i_pc    = pc;
      i_instr = instr;
      #2;
      check_bit("pc_src", jump, o_pc_src);
      check_bit("pc_beq", taken, o_pc_beq);
      check_bit("flush", jump | taken, o_flush);
      if (jump && op == OP_SPECIAL) check_word("jmp_addr", rs_val, o_jmp_addr);
      if (jump && op != OP_SPECIAL) check_word("jmp_addr", {4'b0, instr[25:0], 2'b00}, o_jmp_addr);
      if (op == OP_BEQ || op == OP_BNE) check_word("brh_addr", pc + (sext << 2), o_brh_addr);
      @(posedge i_clk);
      #1;
      check_word("id_ex_pc", pc, o_id_ex_pc);
      check_word("id_ex_rs", rs_val, o_id_ex_rs);
      check_word("id_ex_rt", rt_val, o_id_ex_rt);
      check_word("id_ex_imm", imm, o_id_ex_imm);
      check_num("id_ex_rt_num", instr[20:16], o_id_ex_rt_num);
      check_num("id_ex_rd_num", instr[15:11], o_id_ex_rd_num);
      check_alu("id_ex_alu_op", alu, o_id_ex_alu_op);
      check_src("id_ex_src_a", src, o_id_ex_src_a);
      check_bit("id_ex_src_b_imm", imm_b, o_id_ex_src_b_imm);
      check_dest("id_ex_dest", dest, o_id_ex_dest);
   endtask

   task automatic test_reset();
      test_name = "reset";
      repeat (RESET_CYCLES) @(posedge i_clk);
      #1;
      check_word("id_ex_pc", '0, o_id_ex_pc);
      check_word("id_ex_rs", '0, o_id_ex_rs);
      check_word("id_ex_rt", '0, o_id_ex_rt);
      check_word("id_ex_imm", '0, o_id_ex_imm);
      check_num("id_ex_rt_num", '0, o_id_ex_rt_num);
      check_num("id_ex_rd_num", '0, o_id_ex_rd_num);
      check_alu("id_ex_alu_op", ALU_NONE, o_id_ex_alu_op);
      check_src("id_ex_src_a", SRC_A_PC, o_id_ex_src_a);
      check_bit("id_ex_src_b_imm", 1'b0, o_id_ex_src_b_imm);
      check_dest("id_ex_dest", DEST_RD, o_id_ex_dest);
      check_bit("pc_src", 1'b0, o_pc_src);
      check_bit("pc_beq", 1'b0, o_pc_beq);
      check_bit("flush", 1'b0, o_flush);
      @(negedge i_clk);
      i_rst = 1'b0;
   endtask

   task automatic test_regfile();
      logic [`NB_BITS-1:0] data;
      test_name = "regfile";
      for (int i = 1; i < `N_REGS; i++) write_reg(i[`NB_REG-1:0], $urandom);
      // rt walks down while rs walks up, the last read pairs r31 with r0
      for (int i = 1; i < `N_REGS; i++)
         run_instr(i << 2, {OP_SPECIAL, i[4:0], ~i[4:0], 5'd3, 5'd0, 6'h20});
      data = $urandom;
      @(negedge i_clk);
      i_wb_we   = 1'b1;   // write and read r7 in the same cycle
      i_wb_dst  = 5'd7;
      i_wb_data = data;
      i_instr   = {OP_SPECIAL, 5'd7, 5'd7, 5'd1, 5'd0, 6'h20};
      shadow[7] = data;
      @(posedge i_clk);
      #1;
      check_word("bypass rs", data, o_id_ex_rs);
      check_word("bypass rt", data, o_id_ex_rt);
      run_instr(32'h200, {OP_SPECIAL, 5'd7, 5'd0, 5'd2, 5'd0, 6'h20});
      write_reg(5'd0, $urandom | 32'h1);
      run_instr(32'h204, {OP_SPECIAL, 5'd0, 5'd0, 5'd4, 5'd0, 6'h20});
   endtask

   task automatic test_imm();
      logic [5:0]  ops [8];
      logic [31:0] w;
      test_name = "immediate";
      ops = '{OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW, OP_SW};
      for (int k = 0; k < 8; k++) begin
         for (int n = 0; n < 4; n++) begin
            w     = $urandom;
            w[15] = n[0];   // both signs of the immediate
            run_instr($urandom & ~32'h3, {ops[k], w[25:0]});
         end
      end
   endtask

   task automatic test_special();
      logic [5:0]  fns [6];
      logic [31:0] w;
      test_name = "special";
      fns = '{6'h20, 6'h22, 6'h00, 6'h2a, FN_JR, FN_JALR};
      for (int k = 0; k < 6; k++) begin
         repeat (2) begin
            w = $urandom;
            run_instr($urandom & ~32'h3, {OP_SPECIAL, w[25:6], fns[k]});
         end
      end
   endtask

   task automatic test_branch();
      logic [31:0] v;
      logic [31:0] w;
      test_name = "branch";
      for (int b = 0; b < 2; b++) begin
         for (int eq = 0; eq < 2; eq++) begin
            for (int neg = 0; neg < 2; neg++) begin
               v = $urandom;
               w = $urandom;
               write_reg(5'd10, v);
               write_reg(5'd11, eq ? v : v ^ (w | 32'h1));
               run_instr(32'h0001_0000 + (w[11:0] << 2),
                         {b ? OP_BNE : OP_BEQ, 5'd10, 5'd11, neg[0], w[14:0]});
            end
         end
      end
   endtask

   task automatic test_jump();
      logic [31:0] w;
      test_name = "jump";
      repeat (3) begin
         w = $urandom;
         run_instr($urandom & ~32'h3, {OP_J, w[25:0]});
         run_instr($urandom & ~32'h3, {OP_JAL, ~w[25:0]});
      end
   endtask

   initial begin
      i_rst     = 1'b1;
      i_pc      = '0;
      i_instr   = '0;
      i_wb_data = '0;
      i_wb_dst  = '0;
      i_wb_we   = 1'b0;
      errors    = 0;
      void'($urandom(32'h8dde47c4));
      for (int i = 0; i < `N_REGS; i++) shadow[i] = '0;
      test_reset();
      test_regfile();
      test_imm();
      test_special();
      test_branch();
      test_jump();
      $display("tests done, error count %0d", errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module decode_stage (
   input  logic                i_clk,
   input  logic                i_rst,
   input  logic [`NB_BITS-1:0] i_pc,      // pc+4 of this instruction
   input  logic [`NB_BITS-1:0] i_instr,
   input  logic [`NB_BITS-1:0] i_wb_data,
   input  logic [`NB_REG-1:0]  i_wb_dst,
   input  logic                i_wb_we,
   output logic [`NB_BITS-1:0] o_id_ex_pc,
   output logic [`NB_BITS-1:0] o_id_ex_rs,
   output logic [`NB_BITS-1:0] o_id_ex_rt,
   output logic [`NB_BITS-1:0] o_id_ex_imm,
   output logic [`NB_REG-1:0]  o_id_ex_rt_num,
   output logic [`NB_REG-1:0]  o_id_ex_rd_num,
   output mips_pkg::alu_op_e   o_id_ex_alu_op,
   output mips_pkg::src_a_e    o_id_ex_src_a,
   output logic                o_id_ex_src_b_imm,
   output mips_pkg::dest_e     o_id_ex_dest,
   output logic [`NB_JMP-1:0]  o_jmp_addr,
   output logic [`NB_BITS-1:0] o_brh_addr,
   output logic                o_pc_src,
   output logic                o_pc_beq,
   output logic                o_flush
);

   import mips_pkg::*;

   localparam int NB_IMM = 16;   // i-type immediate
   localparam int NB_IDX = 26;   // j-type index

   opcode_e opcode;
   funct_e  funct;

   logic [`NB_REG-1:0]  rs_num;
   logic [`NB_REG-1:0]  rt_num;
   logic [`NB_REG-1:0]  rd_num;
   logic [`NB_REG-1:0]  shamt;

   logic [`NB_BITS-1:0] rs_data;
   logic [`NB_BITS-1:0] rt_data;
   logic                equal;

   ext_e                ext;
   alu_op_e             alu_op;
   src_a_e              src_a;
   logic                src_b_imm;
   dest_e               dest;
   logic                jmp_reg;

   logic [`NB_BITS-1:0] imm_ext;

   // instruction fields
   assign opcode = opcode_e'(i_instr[31:26]);
   assign funct  = funct_e'(i_instr[5:0]);
   assign rs_num = i_instr[25:21];
   assign rt_num = i_instr[20:16];
   assign rd_num = i_instr[15:11];
   assign shamt  = i_instr[10:6];

   register_file u_register_file (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_rs_addr (rs_num),
      .i_rt_addr (rt_num),
      .i_wr_addr (i_wb_dst),
      .i_wr_data (i_wb_data),
      .i_wr_en   (i_wb_we),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data),
      .o_equal   (equal)
   );

   control_decoder u_control_decoder (
      .i_opcode    (opcode),
      .i_funct     (funct),
      .i_equal     (equal),
      .o_ext       (ext),
      .o_alu_op    (alu_op),
      .o_src_a     (src_a),
      .o_src_b_imm (src_b_imm),
      .o_dest      (dest),
      .o_jmp_reg   (jmp_reg),
      .o_pc_src    (o_pc_src),
      .o_pc_beq    (o_pc_beq),
      .o_flush     (o_flush)
   );

   always_comb begin
      case (ext)
         EXT_JMP:   imm_ext = {{(`NB_BITS-NB_IDX){1'b0}}, i_instr[NB_IDX-1:0]};
         EXT_SGN:   imm_ext = {{(`NB_BITS-NB_IMM){i_instr[NB_IMM-1]}}, i_instr[NB_IMM-1:0]};
         EXT_ZRO:   imm_ext = {{(`NB_BITS-NB_IMM){1'b0}}, i_instr[NB_IMM-1:0]};
         default:   imm_ext = {{(`NB_BITS-`NB_REG){1'b0}}, shamt};
      endcase
   end

   // jr/jalr go to rs as is, j/jal to the word index
   assign o_jmp_addr = jmp_reg ? rs_data[`NB_JMP-1:0]
                               : {{(`NB_JMP-NB_IDX-2){1'b0}}, i_instr[NB_IDX-1:0], 2'b00};

   // branches decode with sign extension, so imm_ext is the offset here
   assign o_brh_addr = i_pc + {imm_ext[`NB_BITS-3:0], 2'b00};

   // id/ex register, a new entry every cycle
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_id_ex_pc        <= '0;
         o_id_ex_rs        <= '0;
         o_id_ex_rt        <= '0;
         o_id_ex_imm       <= '0;
         o_id_ex_rt_num    <= '0;
         o_id_ex_rd_num    <= '0;
         o_id_ex_alu_op    <= ALU_NONE;
         o_id_ex_src_a     <= SRC_A_PC;
         o_id_ex_src_b_imm <= 1'b0;
         o_id_ex_dest      <= DEST_RD;
      end else begin
         o_id_ex_pc        <= i_pc;
         o_id_ex_rs        <= rs_data;
         o_id_ex_rt        <= rt_data;
         o_id_ex_imm       <= imm_ext;
         o_id_ex_rt_num    <= rt_num;
         o_id_ex_rd_num    <= rd_num;
         o_id_ex_alu_op    <= alu_op;
         o_id_ex_src_a     <= src_a;
         o_id_ex_src_b_imm <= src_b_imm;
         o_id_ex_dest      <= dest;
      end
   end

   // fetch only squashes on a real redirect
   flush_has_cause: assert property (@(posedge i_clk) disable iff (i_rst)
      o_flush |-> (o_pc_src || o_pc_beq))
      else $error("flush without jump or taken branch");

endmodule

`default_nettype wire

/* logic/control_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module control_decoder (
   input  mips_pkg::opcode_e i_opcode,
   input  mips_pkg::funct_e  i_funct,
   input  logic              i_equal,
   output mips_pkg::ext_e    o_ext,
   output mips_pkg::alu_op_e o_alu_op,
   output mips_pkg::src_a_e  o_src_a,
   output logic              o_src_b_imm,
   output mips_pkg::dest_e   o_dest,
   output logic              o_jmp_reg,
   output logic              o_pc_src,
   output logic              o_pc_beq,
   output logic              o_flush
);

   import mips_pkg::*;

   logic is_jr;   // jr or jalr in the funct field

   assign is_jr = (i_funct == FN_JR) || (i_funct == FN_JALR);

   always_comb begin
      // unknown opcodes behave like a nop
      o_ext       = EXT_SGN;
      o_alu_op    = ALU_NONE;
      o_src_a     = SRC_A_PC;
      o_src_b_imm = 1'b0;
      o_dest      = DEST_RD;
      o_jmp_reg   = 1'b0;
      o_pc_src    = 1'b0;
      o_pc_beq    = 1'b0;

      case (i_opcode)
         OP_J: begin
            o_ext    = EXT_JMP;
            o_pc_src = 1'b1;
         end
         OP_JAL: begin
            o_ext    = EXT_JMP;
            o_alu_op = ALU_JAL;   // return address through the alu
            o_dest   = DEST_R31;
            o_pc_src = 1'b1;
         end
         OP_BEQ: begin
            o_pc_beq = i_equal;
         end
         OP_BNE: begin
            o_pc_beq = !i_equal;
         end
         OP_ADDI: begin
            o_alu_op    = ALU_ADD;
            o_src_a     = SRC_A_RS;
            o_src_b_imm = 1'b1;
            o_dest      = DEST_RT;
         end
         OP_SLTI: begin
            o_alu_op    = ALU_SLT;
            o_src_a     = SRC_A_RS;
            o_src_b_imm = 1'b1;
            o_dest      = DEST_RT;
         end
         OP_ANDI: begin
            o_ext       = EXT_ZRO;   // logic ops take the raw 16 bits
            o_alu_op    = ALU_AND;
            o_src_a     = SRC_A_RS;
            o_src_b_imm = 1'b1;
            o_dest      = DEST_RT;
         end
         OP_ORI: begin
            o_ext       = EXT_ZRO;
            o_alu_op    = ALU_OR;
            o_src_a     = SRC_A_RS;
            o_src_b_imm = 1'b1;
            o_dest      = DEST_RT;
         end
         OP_XORI: begin
            o_ext       = EXT_ZRO;
            o_alu_op    = ALU_XOR;
            o_src_a     = SRC_A_RS;
            o_src_b_imm = 1'b1;
            o_dest      = DEST_RT;
         end
         OP_LUI: begin
            o_ext       = EXT_ZRO;
            o_alu_op    = ALU_LUI;   // alu shifts the immediate up
            o_src_b_imm = 1'b1;
            o_dest      = DEST_RT;
         end
         OP_LW, OP_SW: begin
            // base plus offset
            o_alu_op    = ALU_ADD;
            o_src_a     = SRC_A_RS;
            o_src_b_imm = 1'b1;
            o_dest      = DEST_RT;
         end
         OP_SPECIAL: begin
            o_ext     = EXT_SHAMT;
            o_alu_op  = ALU_FUNC;
            o_src_a   = SRC_A_SHAMT;
            o_jmp_reg = is_jr;
            o_pc_src  = is_jr;
         end
         default: begin
         end
      endcase
   end

   assign o_flush = o_pc_src | o_pc_beq;   // squash the slot in fetch

   // a jump and a taken branch cannot come from one opcode
   always_comb begin
      redirect_excl: assert final (!(o_pc_src && o_pc_beq))
         else $error("jump and branch redirect at once");
   end

endmodule

`default_nettype wire

/* logic/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mips_macros.svh"

module register_file (
   input  logic                i_clk,
   input  logic                i_rst,
   input  logic [`NB_REG-1:0]  i_rs_addr,
   input  logic [`NB_REG-1:0]  i_rt_addr,
   input  logic [`NB_REG-1:0]  i_wr_addr,
   input  logic [`NB_BITS-1:0] i_wr_data,
   input  logic                i_wr_en,
   output logic [`NB_BITS-1:0] o_rs_data,
   output logic [`NB_BITS-1:0] o_rt_data,
   output logic                o_equal
);

   logic [`NB_BITS-1:0] regs [`N_REGS];

   logic wr_valid;   // write that actually lands in the array
   logic rs_bypass;
   logic rt_bypass;

   assign wr_valid = i_wr_en && (i_wr_addr != '0);

   // write-back and decode in the same cycle, forward the new value
   assign rs_bypass = wr_valid && (i_rs_addr == i_wr_addr);
   assign rt_bypass = wr_valid && (i_rt_addr == i_wr_addr);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < `N_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_valid) begin
         regs[i_wr_addr] <= i_wr_data;
      end
   end

   // r0 is cleared on reset and never written
   always_comb begin
      if (rs_bypass) begin
         o_rs_data = i_wr_data;
      end else begin
         o_rs_data = regs[i_rs_addr];
      end
   end

   always_comb begin
      if (rt_bypass) begin
         o_rt_data = i_wr_data;
      end else begin
         o_rt_data = regs[i_rt_addr];
      end
   end

   assign o_equal = (o_rs_data == o_rt_data);   // beq / bne resolution

   // r0 stays zero, also right after a write-back aimed at it
   r0_reads_zero: assert property (@(posedge i_clk) disable iff (i_rst)
      ((i_rs_addr == '0) |-> (o_rs_data == '0)) and
      ((i_rt_addr == '0) |-> (o_rt_data == '0)))
      else $error("register 0 read back nonzero");

endmodule

`default_nettype wire

/* logic/mips_pkg.sv */
`default_nettype none

package mips_pkg;

   // primary opcodes, instr[31:26]
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'd0,  // r-type, operation in funct
      OP_J       = 6'd2,
      OP_JAL     = 6'd3,
      OP_BEQ     = 6'd4,
      OP_BNE     = 6'd5,
      OP_ADDI    = 6'd8,
      OP_SLTI    = 6'd10,
      OP_ANDI    = 6'd12,
      OP_ORI     = 6'd13,
      OP_XORI    = 6'd14,
      OP_LUI     = 6'd15,
      OP_LW      = 6'd35,
      OP_SW      = 6'd43
   } opcode_e;

   // special function codes that redirect the pc
   typedef enum logic [5:0] {
      FN_JR   = 6'd8,
      FN_JALR = 6'd9
   } funct_e;

   // operation handed to execute
   typedef enum logic [3:0] {
      ALU_NONE = 4'd0,
      ALU_ADD  = 4'd1,
      ALU_SLT  = 4'd2,
      ALU_AND  = 4'd3,
      ALU_OR   = 4'd4,
      ALU_XOR  = 4'd5,
      ALU_LUI  = 4'd6,
      ALU_JAL  = 4'd7,  // link value pc+8 computed in execute
      ALU_FUNC = 4'd8   // execute decodes instr[5:0] itself
   } alu_op_e;

   // immediate extension modes
   typedef enum logic [1:0] {
      EXT_JMP   = 2'd0,  // 26 bit index, zero filled
      EXT_SGN   = 2'd1,
      EXT_ZRO   = 2'd2,
      EXT_SHAMT = 2'd3   // instr[10:6]
   } ext_e;

   // first alu operand
   typedef enum logic [1:0] {
      SRC_A_PC    = 2'd0,
      SRC_A_RS    = 2'd1,
      SRC_A_SHAMT = 2'd2
   } src_a_e;

   // write-back register select
   typedef enum logic [1:0] {
      DEST_RD  = 2'd0,
      DEST_RT  = 2'd1,
      DEST_R31 = 2'd2  // link register
   } dest_e;

endpackage

`default_nettype wire

/* logic/mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// datapath widths shared by the decode stage and its register file

// one data word, also the width of every pc and address
`define NB_BITS 32

// register number field in rs / rt / rd
`define NB_REG  5

// size of the architectural register file
`define N_REGS  32

// jump target bus towards fetch
`define NB_JMP  32

`endif
